//--- Makefile
# Verilator flow for the stack processor testbench

VERILATOR  ?= verilator
TOP        ?= wasm_cpu_tb
FILELIST   ?= build.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= Done: no errors
LINT_FLAGS ?= --lint-only --timing --assert -Wall
VFLAGS     ?= --binary --timing --assert -Wno-fatal
SIM_ARGS   ?= +verilator+error+limit+100

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -qF "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- build.f
src/wasm_isa_pkg.sv
src/wasm_core_pkg.sv
src/program_rom.sv
src/leb128_decoder.sv
src/operand_stack.sv
src/value_alu.sv
src/wasm_core.sv
src/wasm_cpu.sv
verification/wasm_cpu_assert.sv
verification/wasm_cpu_checker.sv
verification/wasm_cpu_tb.sv

//--- src/leb128_decoder.sv
`timescale 1ns/1ps

module leb128_decoder (
  input  wasm_core_pkg::rom_byte_t [wasm_core_pkg::IMM_MAX_BYTES-1:0] imm_bytes,
  output wasm_core_pkg::value_t                                       imm_value,
  output wasm_core_pkg::imm_len_t                                     imm_len
);

  // Seven payload bits per byte
  localparam int GROUP_BITS = 7 * wasm_core_pkg::IMM_MAX_BYTES;

  always_comb begin
    logic [GROUP_BITS-1:0] groups;
    logic                  done;

    groups  = '0;
    done    = 1'b0;
    imm_len = wasm_core_pkg::imm_len_t'(wasm_core_pkg::IMM_MAX_BYTES);

    for (int i = 0; i < wasm_core_pkg::IMM_MAX_BYTES; i++) begin
      if (!done) begin
        groups[7*i +: 7] = imm_bytes[i][6:0];
        // Clear continuation bit ends the number
        if (!imm_bytes[i][7]) begin
          done    = 1'b1;
          imm_len = wasm_core_pkg::imm_len_t'(i + 1);
          // Sign fill from bit 6 of the last byte
          for (int j = 0; j < GROUP_BITS; j++) begin
            if (j >= 7 * (i + 1)) begin
              groups[j] = imm_bytes[i][6];
            end
          end
        end
      end
    end

    imm_value = groups[63:0];
  end

endmodule

//--- src/operand_stack.sv
`timescale 1ns/1ps

module operand_stack #(
  parameter int STACK_DEPTH_BITS = 3
) (
  input  logic                         clk,
  input  logic                         reset,
  input  wasm_core_pkg::stack_op_t     stack_op,
  input  wasm_core_pkg::stack_entry_t  stack_push,
  output wasm_core_pkg::stack_entry_t  tos,
  output wasm_core_pkg::stack_entry_t  nos,
  output logic [STACK_DEPTH_BITS:0]    depth
);

  localparam int ENTRIES = 2 ** STACK_DEPTH_BITS;

  wasm_core_pkg::stack_entry_t entries [ENTRIES];

  logic [STACK_DEPTH_BITS-1:0] top_idx;
  logic [STACK_DEPTH_BITS-1:0] next_idx;
  logic [STACK_DEPTH_BITS-1:0] free_idx;

  // Slot indices relative to the depth counter
  assign top_idx  = STACK_DEPTH_BITS'(depth - 1'b1);
  assign next_idx = STACK_DEPTH_BITS'(depth - 2'd2);
  assign free_idx = depth[STACK_DEPTH_BITS-1:0];

  // Top two entries, only meaningful when depth covers them
  assign tos = entries[top_idx];
  assign nos = entries[next_idx];

  always_ff @(posedge clk) begin
    if (reset) begin
      depth <= '0;
    end else begin
      case (stack_op)
        wasm_core_pkg::STACK_PUSH:        depth <= depth + 1'b1;
        wasm_core_pkg::STACK_POP,
        wasm_core_pkg::STACK_POP_REPLACE: depth <= depth - 1'b1;
        default: ;
      endcase
    end
  end

  // Slot writes
  always_ff @(posedge clk) begin
    case (stack_op)
      wasm_core_pkg::STACK_PUSH:        entries[free_idx] <= stack_push;
      wasm_core_pkg::STACK_REPLACE:     entries[top_idx]  <= stack_push;
      // Binary result lands on the entry below the old top
      wasm_core_pkg::STACK_POP_REPLACE: entries[next_idx] <= stack_push;
      default: ;
    endcase
  end

endmodule

//--- src/program_rom.sv
`timescale 1ns/1ps

module program_rom #(
  parameter int ROM_ADDR_BITS = 6
) (
  input  logic                                                          clk,
  input  logic                                                          load_en,
  input  logic [ROM_ADDR_BITS-1:0]                                      load_addr,
  input  wasm_core_pkg::rom_byte_t                                      load_byte,
  input  logic [ROM_ADDR_BITS-1:0]                                      rom_addr,
  output wasm_core_pkg::rom_byte_t [wasm_core_pkg::ROM_WINDOW_BYTES-1:0] rom_window
);

  localparam int ROM_SIZE = 2 ** ROM_ADDR_BITS;

  wasm_core_pkg::rom_byte_t mem [ROM_SIZE];

  // Byte writes from the testbench loader
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_byte;
    end
  end

  // Registered window, top bit of addr marks a read past the end
  always_ff @(posedge clk) begin
    for (int i = 0; i < wasm_core_pkg::ROM_WINDOW_BYTES; i++) begin
      logic [ROM_ADDR_BITS:0] addr;
      addr = {1'b0, rom_addr} + (ROM_ADDR_BITS + 1)'(i);
      if (addr[ROM_ADDR_BITS]) begin
        rom_window[i] <= '0;
      end else begin
        rom_window[i] <= mem[addr[ROM_ADDR_BITS-1:0]];
      end
    end
  end

endmodule

//--- src/value_alu.sv
`timescale 1ns/1ps

module value_alu (
  input  wasm_core_pkg::alu_op_t      alu_op,
  input  wasm_core_pkg::stack_entry_t tos,
  input  wasm_core_pkg::stack_entry_t nos,
  input  wasm_isa_pkg::val_type_t     op_type,
  output wasm_core_pkg::stack_entry_t alu_result,
  output logic                        alu_mismatch
);

  logic                  binary;
  wasm_core_pkg::value_t mask;
  wasm_core_pkg::value_t a;
  wasm_core_pkg::value_t b;
  logic                  flag;

  assign binary = (alu_op != wasm_core_pkg::ALU_EQZ);

  // eqz only inspects the top entry
  assign alu_mismatch = (tos.tag != op_type) || (binary && (nos.tag != op_type));

  // i32 works on the low word only
  assign mask = (op_type == wasm_isa_pkg::TYPE_I32) ? 64'h0000_0000_FFFF_FFFF : '1;
  assign a    = nos.value & mask;
  assign b    = tos.value & mask;

  always_comb begin
    flag       = 1'b0;
    alu_result = '{tag: op_type, value: '0};
    case (alu_op)
      wasm_core_pkg::ALU_ADD: alu_result.value = (a + b) & mask;
      // Second entry minus the top
      wasm_core_pkg::ALU_SUB: alu_result.value = (a - b) & mask;
      wasm_core_pkg::ALU_EQ:  flag = (a == b);
      wasm_core_pkg::ALU_NE:  flag = (a != b);
      wasm_core_pkg::ALU_EQZ: flag = (b == '0);
      default: ;
    endcase
    // Comparisons always produce an i32 boolean
    if (alu_op inside {wasm_core_pkg::ALU_EQ, wasm_core_pkg::ALU_NE, wasm_core_pkg::ALU_EQZ})
    begin
      alu_result.tag   = wasm_isa_pkg::TYPE_I32;
      alu_result.value = {63'b0, flag};
    end
  end

endmodule

//--- src/wasm_core.sv
`timescale 1ns/1ps

module wasm_core #(
  parameter int ROM_ADDR_BITS    = 6,
  parameter int STACK_DEPTH_BITS = 3
) (
  input  logic                                                          clk,
  input  logic                                                          reset,
  input  wasm_core_pkg::rom_byte_t [wasm_core_pkg::ROM_WINDOW_BYTES-1:0] rom_window,
  input  wasm_core_pkg::value_t                                         imm_value,
  input  wasm_core_pkg::imm_len_t                                       imm_len,
  input  wasm_core_pkg::stack_entry_t                                   tos,
  input  logic [STACK_DEPTH_BITS:0]                                     depth,
  input  wasm_core_pkg::stack_entry_t                                   alu_result,
  input  logic                                                          alu_mismatch,
  output logic [ROM_ADDR_BITS-1:0]                                      rom_addr,
  output wasm_core_pkg::stack_op_t                                      stack_op,
  output wasm_core_pkg::stack_entry_t                                   stack_push,
  output wasm_core_pkg::alu_op_t                                        alu_op,
  output wasm_isa_pkg::val_type_t                                       op_type,
  output wasm_isa_pkg::trap_t                                           trap
);

  localparam logic [STACK_DEPTH_BITS:0] DEPTH_ONE  = 1;
  localparam logic [STACK_DEPTH_BITS:0] STACK_FULL = {1'b1, {STACK_DEPTH_BITS{1'b0}}};

  wasm_core_pkg::core_state_t state;
  logic [ROM_ADDR_BITS-1:0]   pc;
  logic [ROM_ADDR_BITS-1:0]   next_pc;
  wasm_isa_pkg::opcode_t      opcode;
  logic                       use_alu;
  logic                       binary;
  wasm_core_pkg::stack_op_t   exec_op;
  wasm_isa_pkg::trap_t        exec_trap;

  assign opcode = rom_window[0];

  // Opcode class, kept apart from the ALU feedback
  always_comb begin
    use_alu = 1'b1;
    binary  = 1'b1;
    alu_op  = wasm_core_pkg::ALU_ADD;
    case (opcode)
      wasm_isa_pkg::OP_I32_ADD, wasm_isa_pkg::OP_I64_ADD: alu_op = wasm_core_pkg::ALU_ADD;
      wasm_isa_pkg::OP_I32_SUB, wasm_isa_pkg::OP_I64_SUB: alu_op = wasm_core_pkg::ALU_SUB;
      wasm_isa_pkg::OP_I32_EQ,  wasm_isa_pkg::OP_I64_EQ:  alu_op = wasm_core_pkg::ALU_EQ;
      wasm_isa_pkg::OP_I32_NE,  wasm_isa_pkg::OP_I64_NE:  alu_op = wasm_core_pkg::ALU_NE;
      wasm_isa_pkg::OP_I32_EQZ, wasm_isa_pkg::OP_I64_EQZ: begin
        alu_op = wasm_core_pkg::ALU_EQZ;
        binary = 1'b0;
      end
      default: begin
        use_alu = 1'b0;
        binary  = 1'b0;
      end
    endcase
    op_type = (opcode inside {wasm_isa_pkg::OP_I64_EQZ, wasm_isa_pkg::OP_I64_EQ,
                              wasm_isa_pkg::OP_I64_NE, wasm_isa_pkg::OP_I64_ADD,
                              wasm_isa_pkg::OP_I64_SUB}) ? wasm_isa_pkg::TYPE_I64
                                                          : wasm_isa_pkg::TYPE_I32;
  end

  // Stack effect and trap of the current instruction
  always_comb begin
    exec_op   = wasm_core_pkg::STACK_NONE;
    exec_trap = wasm_isa_pkg::TRAP_NONE;
    // Idle bus mirrors the top entry
    stack_push = tos;
    next_pc    = pc + 1'b1;
    if (use_alu) begin
      if (depth == '0 || (binary && depth == DEPTH_ONE)) begin
        exec_trap = wasm_isa_pkg::TRAP_STACK_EMPTY;
      end else if (alu_mismatch) begin
        exec_trap = wasm_isa_pkg::TRAP_TYPE_MISMATCH;
      end else begin
        exec_op    = binary ? wasm_core_pkg::STACK_POP_REPLACE : wasm_core_pkg::STACK_REPLACE;
        stack_push = alu_result;
      end
    end else begin
      case (opcode)
        wasm_isa_pkg::OP_UNREACHABLE: exec_trap = wasm_isa_pkg::TRAP_UNREACHABLE;
        wasm_isa_pkg::OP_NOP: ;
        wasm_isa_pkg::OP_END:         exec_trap = wasm_isa_pkg::TRAP_ENDED;
        wasm_isa_pkg::OP_DROP: begin
          if (depth == '0) begin
            exec_trap = wasm_isa_pkg::TRAP_STACK_EMPTY;
          end else begin
            exec_op = wasm_core_pkg::STACK_POP;
          end
        end
        wasm_isa_pkg::OP_I32_CONST, wasm_isa_pkg::OP_I64_CONST: begin
          // Skip the immediate as well
          next_pc = pc + ROM_ADDR_BITS'(imm_len) + 1'b1;
          if (depth == STACK_FULL) begin
            exec_trap = wasm_isa_pkg::TRAP_STACK_OVERFLOW;
          end else if (opcode == wasm_isa_pkg::OP_I64_CONST) begin
            exec_op    = wasm_core_pkg::STACK_PUSH;
            stack_push = '{tag: wasm_isa_pkg::TYPE_I64, value: imm_value};
          end else begin
            exec_op    = wasm_core_pkg::STACK_PUSH;
            stack_push = '{tag: wasm_isa_pkg::TYPE_I32, value: {32'b0, imm_value[31:0]}};
          end
        end
        default: exec_trap = wasm_isa_pkg::TRAP_UNKNOWN_OPCODE;
      endcase
    end
  end

  // Stack strobe only in exec of a running core
  assign stack_op = (state == wasm_core_pkg::ST_EXEC && trap == wasm_isa_pkg::TRAP_NONE)
                  ? exec_op : wasm_core_pkg::STACK_NONE;

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= wasm_core_pkg::ST_FETCH;
      pc       <= '0;
      rom_addr <= '0;
      trap     <= wasm_isa_pkg::TRAP_NONE;
    end else if (trap == wasm_isa_pkg::TRAP_NONE) begin
      case (state)
        wasm_core_pkg::ST_FETCH: begin
          rom_addr <= pc;
          state    <= wasm_core_pkg::ST_WAIT_ROM;
        end
        // Window is registered during this cycle
        wasm_core_pkg::ST_WAIT_ROM: state <= wasm_core_pkg::ST_EXEC;
        wasm_core_pkg::ST_EXEC: begin
          state <= wasm_core_pkg::ST_FETCH;
          trap  <= exec_trap;
          if (exec_trap == wasm_isa_pkg::TRAP_NONE) begin
            pc <= next_pc;
          end
        end
        default: state <= wasm_core_pkg::ST_FETCH;
      endcase
    end
  end

endmodule

//--- src/wasm_core_pkg.sv
package wasm_core_pkg;

  // Opcode byte plus the longest immediate
  localparam int IMM_MAX_BYTES    = 10;
  localparam int ROM_WINDOW_BYTES = 11;

  typedef logic [7:0]  rom_byte_t;
  typedef logic [63:0] value_t;

  // Bytes taken by a LEB128 immediate, 1 to 10
  typedef logic [3:0] imm_len_t;

  // One operand stack slot, 66 bits
  typedef struct packed {
    wasm_isa_pkg::val_type_t tag;
    value_t                  value;
  } stack_entry_t;

  typedef enum logic [2:0] {
    STACK_NONE,
    STACK_PUSH,
    STACK_POP,
    STACK_REPLACE,
    STACK_POP_REPLACE
  } stack_op_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_EQ,
    ALU_NE,
    ALU_EQZ
  } alu_op_t;

  typedef enum logic [1:0] {
    ST_FETCH,
    ST_WAIT_ROM,
    ST_EXEC
  } core_state_t;

endpackage

//--- src/wasm_cpu.sv
`timescale 1ns/1ps

module wasm_cpu #(
  parameter int ROM_ADDR_BITS    = 6,
  parameter int STACK_DEPTH_BITS = 3
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     load_en,
  input  logic [ROM_ADDR_BITS-1:0] load_addr,
  input  wasm_core_pkg::rom_byte_t load_byte,
  output wasm_core_pkg::value_t    result,
  output wasm_isa_pkg::val_type_t  result_type,
  output logic                     result_empty,
  output wasm_isa_pkg::trap_t      trap
);

  wasm_core_pkg::rom_byte_t [wasm_core_pkg::ROM_WINDOW_BYTES-1:0] rom_window;
  logic [ROM_ADDR_BITS-1:0]    rom_addr;
  wasm_core_pkg::value_t       imm_value;
  wasm_core_pkg::imm_len_t     imm_len;
  wasm_core_pkg::stack_op_t    stack_op;
  wasm_core_pkg::stack_entry_t stack_push;
  wasm_core_pkg::stack_entry_t tos;
  wasm_core_pkg::stack_entry_t nos;
  logic [STACK_DEPTH_BITS:0]   depth;
  wasm_core_pkg::alu_op_t      alu_op;
  wasm_isa_pkg::val_type_t     op_type;
  wasm_core_pkg::stack_entry_t alu_result;
  logic                        alu_mismatch;

  // Top of stack is the visible result
  assign result       = tos.value;
  assign result_type  = tos.tag;
  assign result_empty = (depth == '0);

  program_rom #(.ROM_ADDR_BITS(ROM_ADDR_BITS)) u_rom (
    .clk(clk), .load_en(load_en), .load_addr(load_addr), .load_byte(load_byte),
    .rom_addr(rom_addr), .rom_window(rom_window)
  );

  // Bytes after the opcode hold the immediate
  leb128_decoder u_leb128 (
    .imm_bytes(rom_window[wasm_core_pkg::ROM_WINDOW_BYTES-1:1]),
    .imm_value(imm_value), .imm_len(imm_len)
  );

  operand_stack #(.STACK_DEPTH_BITS(STACK_DEPTH_BITS)) u_stack (
    .clk(clk), .reset(reset), .stack_op(stack_op), .stack_push(stack_push),
    .tos(tos), .nos(nos), .depth(depth)
  );

  value_alu u_alu (
    .alu_op(alu_op), .tos(tos), .nos(nos), .op_type(op_type),
    .alu_result(alu_result), .alu_mismatch(alu_mismatch)
  );

  wasm_core #(
    .ROM_ADDR_BITS(ROM_ADDR_BITS),
    .STACK_DEPTH_BITS(STACK_DEPTH_BITS)
  ) u_core (
    .clk(clk), .reset(reset), .rom_window(rom_window), .imm_value(imm_value),
    .imm_len(imm_len), .tos(tos), .depth(depth), .alu_result(alu_result),
    .alu_mismatch(alu_mismatch), .rom_addr(rom_addr), .stack_op(stack_op),
    .stack_push(stack_push), .alu_op(alu_op), .op_type(op_type), .trap(trap)
  );

endmodule

//--- src/wasm_isa_pkg.sv
package wasm_isa_pkg;

  // Opcode byte as read from program memory
  typedef logic [7:0] opcode_t;

  // Control
  localparam opcode_t OP_UNREACHABLE = 8'h00;
  localparam opcode_t OP_NOP         = 8'h01;
  localparam opcode_t OP_END         = 8'h0B;
  localparam opcode_t OP_DROP        = 8'h1A;

  // Constants, LEB128 immediate follows the opcode
  localparam opcode_t OP_I32_CONST   = 8'h41;
  localparam opcode_t OP_I64_CONST   = 8'h42;

  // Comparisons
  localparam opcode_t OP_I32_EQZ     = 8'h45;
  localparam opcode_t OP_I32_EQ      = 8'h46;
  localparam opcode_t OP_I32_NE      = 8'h47;
  localparam opcode_t OP_I64_EQZ     = 8'h50;
  localparam opcode_t OP_I64_EQ      = 8'h51;
  localparam opcode_t OP_I64_NE      = 8'h52;

  // Arithmetic
  localparam opcode_t OP_I32_ADD     = 8'h6A;
  localparam opcode_t OP_I32_SUB     = 8'h6B;
  localparam opcode_t OP_I64_ADD     = 8'h7C;
  localparam opcode_t OP_I64_SUB     = 8'h7D;

  // Type tag carried by every stack entry
  typedef enum logic [1:0] {
    TYPE_I32 = 2'd0,
    TYPE_I64 = 2'd1
  } val_type_t;

  // Halt reason, TRAP_NONE while running
  typedef enum logic [3:0] {
    TRAP_NONE,
    TRAP_ENDED,
    TRAP_UNREACHABLE,
    TRAP_STACK_EMPTY,
    TRAP_STACK_OVERFLOW,
    TRAP_TYPE_MISMATCH,
    TRAP_UNKNOWN_OPCODE
  } trap_t;

endpackage

//--- verification/wasm_cpu_assert.sv
`timescale 1ns/1ps

module wasm_cpu_assert #(
  parameter int STACK_DEPTH_BITS = 3
) (
  input logic                      clk,
  input logic                      reset,
  input wasm_core_pkg::stack_op_t  stack_op,
  input logic [STACK_DEPTH_BITS:0] depth,
  input wasm_isa_pkg::trap_t       trap
);

  localparam logic [STACK_DEPTH_BITS:0] FULL = 2 ** STACK_DEPTH_BITS;

  int failures = 0;

  pop_needs_entry: assert property (@(posedge clk) disable iff (reset)
    (stack_op == wasm_core_pkg::STACK_POP || stack_op == wasm_core_pkg::STACK_POP_REPLACE)
      |-> depth != '0)
    else begin
      failures++;
      $error("pop issued while the stack is empty");
    end

  push_needs_room: assert property (@(posedge clk) disable iff (reset)
    (stack_op == wasm_core_pkg::STACK_PUSH) |-> depth != FULL)
    else begin
      failures++;
      $error("push issued while the stack is full");
    end

  // Halt reason is sticky
  trap_holds: assert property (@(posedge clk) disable iff (reset)
    (trap != wasm_isa_pkg::TRAP_NONE) |=> $stable(trap))
    else begin
      failures++;
      $error("trap changed without a reset");
    end

  empty_after_reset: assert property (@(posedge clk) $fell(reset) |-> depth == '0)
    else begin
      failures++;
      $error("stack not empty in the first cycle after reset");
    end

endmodule

bind wasm_core wasm_cpu_assert #(.STACK_DEPTH_BITS(STACK_DEPTH_BITS)) assert0 (
  .clk(clk), .reset(reset), .stack_op(stack_op), .depth(depth), .trap(trap)
);

//--- verification/wasm_cpu_checker.sv
`timescale 1ns/1ps

module wasm_cpu_checker #(
  parameter int NAME_BITS = 160
) (
  input  logic                    clk,
  input  logic                    reset,
  input  wasm_isa_pkg::trap_t     trap,
  input  logic                    result_empty,
  input  wasm_isa_pkg::val_type_t result_type,
  input  wasm_core_pkg::value_t   result,
  input  logic [NAME_BITS-1:0]    row_name,
  input  wasm_isa_pkg::trap_t     exp_trap,
  input  logic                    exp_empty,
  input  wasm_isa_pkg::val_type_t exp_type,
  input  wasm_core_pkg::value_t   exp_result,
  output int                      error_count,
  output int                      check_count
);

  logic seen_halt;

  initial begin
    error_count = 0;
    check_count = 0;
    seen_halt   = 1'b0;
  end

  // Name arrives right aligned with zero fill
  function automatic string name_text(input logic [NAME_BITS-1:0] raw);
    string      s;
    logic [7:0] c;
    s = "";
    for (int i = NAME_BITS / 8 - 1; i >= 0; i--) begin
      c = raw[8*i +: 8];
      if (c != 8'h00) begin
        s = $sformatf("%s%c", s, c);
      end
    end
    return s;
  endfunction

  task automatic mismatch(input string what, input string expected, input string actual);
    error_count++;
    $display("** Error %0s: %0s expected %0s, actual %0s",
             name_text(row_name), what, expected, actual);
  endtask

  // Sample away from the rising edge, compare once per halt
  always @(negedge clk) begin
    if (reset) begin
      seen_halt = 1'b0;
    end else if (trap != wasm_isa_pkg::TRAP_NONE && !seen_halt) begin
      seen_halt = 1'b1;
      check_count++;
      if (trap !== exp_trap) begin
        mismatch("trap", exp_trap.name(), trap.name());
      end
      if (result_empty !== exp_empty) begin
        mismatch("result_empty", $sformatf("%b", exp_empty), $sformatf("%b", result_empty));
      end
      // Top entry only means something on a non-empty stack
      if (!exp_empty && result_type !== exp_type) begin
        mismatch("result_type", exp_type.name(), result_type.name());
      end
      if (!exp_empty && result !== exp_result) begin
        mismatch("result", $sformatf("%h", exp_result), $sformatf("%h", result));
      end
    end
  end

endmodule

//--- verification/wasm_cpu_tb.sv
`timescale 1ns/1ps

module wasm_cpu_tb;

  localparam int ROM_ADDR_BITS    = 6;
  localparam int STACK_DEPTH_BITS = 3;
  localparam int NUM_ROWS         = 19;
  localparam int MAX_BYTES        = 24;
  localparam int NAME_BITS        = 8 * 20;
  localparam int CLK_PERIOD       = 10;
  localparam int RESET_CYCLES     = 4;

  localparam wasm_isa_pkg::trap_t     ENDED       = wasm_isa_pkg::TRAP_ENDED;
  localparam wasm_isa_pkg::trap_t     UNREACH     = wasm_isa_pkg::TRAP_UNREACHABLE;
  localparam wasm_isa_pkg::trap_t     STACK_EMPTY = wasm_isa_pkg::TRAP_STACK_EMPTY;
  localparam wasm_isa_pkg::trap_t     OVERFLOW    = wasm_isa_pkg::TRAP_STACK_OVERFLOW;
  localparam wasm_isa_pkg::trap_t     MISMATCH    = wasm_isa_pkg::TRAP_TYPE_MISMATCH;
  localparam wasm_isa_pkg::trap_t     UNKNOWN     = wasm_isa_pkg::TRAP_UNKNOWN_OPCODE;
  localparam wasm_isa_pkg::val_type_t I32         = wasm_isa_pkg::TYPE_I32;
  localparam wasm_isa_pkg::val_type_t I64         = wasm_isa_pkg::TYPE_I64;

  // State of the DUT expected at halt
  typedef struct packed {
    wasm_isa_pkg::trap_t     trap;
    logic                    empty;
    wasm_isa_pkg::val_type_t vtype;
    wasm_core_pkg::value_t   value;
  } expect_t;

  logic                     clk;
  logic                     reset;
  logic                     load_en;
  logic [ROM_ADDR_BITS-1:0] load_addr;
  wasm_core_pkg::rom_byte_t load_byte;
  wasm_core_pkg::value_t    result;
  wasm_isa_pkg::val_type_t  result_type;
  logic                     result_empty;
  wasm_isa_pkg::trap_t      trap;

  // Program table with the first byte in the top bits of the code
  logic [NAME_BITS-1:0]   row_name [NUM_ROWS];
  int                     row_len  [NUM_ROWS];
  logic [8*MAX_BYTES-1:0] row_code [NUM_ROWS];
  expect_t                row_exp  [NUM_ROWS];
  int                     row_count;
  int                     current_row;
  logic                   table_ready;

  logic [NAME_BITS-1:0] cur_name;
  expect_t              cur_exp;
  int                   error_count;
  int                   check_count;
  int                   assert_failures;

  wasm_cpu #(
    .ROM_ADDR_BITS(ROM_ADDR_BITS),
    .STACK_DEPTH_BITS(STACK_DEPTH_BITS)
  ) dut0 (
    .clk(clk), .reset(reset), .load_en(load_en), .load_addr(load_addr),
    .load_byte(load_byte), .result(result), .result_type(result_type),
    .result_empty(result_empty), .trap(trap)
  );

  wasm_cpu_checker #(.NAME_BITS(NAME_BITS)) chk0 (
    .clk(clk), .reset(reset), .trap(trap), .result_empty(result_empty),
    .result_type(result_type), .result(result), .row_name(cur_name),
    .exp_trap(cur_exp.trap), .exp_empty(cur_exp.empty), .exp_type(cur_exp.vtype),
    .exp_result(cur_exp.value), .error_count(error_count), .check_count(check_count)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic expect_t expect_of(input wasm_isa_pkg::trap_t t, input logic empty,
                                        input wasm_isa_pkg::val_type_t vt,
                                        input logic [63:0] v);
    return '{trap: t, empty: empty, vtype: vt, value: v};
  endfunction

  task automatic add_row(input logic [NAME_BITS-1:0] name, input int len,
                         input logic [8*MAX_BYTES-1:0] code, input expect_t exp);
    row_name[row_count] = name;
    row_len[row_count]  = len;
    row_code[row_count] = code;
    row_exp[row_count]  = exp;
    row_count++;
  endtask

  task automatic build_table();
    // Constants -123456 and the 10-byte minimum i64
    add_row("i32_const_neg", 5, 40'h41_C0BB78_0B,
            expect_of(ENDED, 1'b0, I32, 64'h0000_0000_FFFE_1DC0));
    add_row("i64_const_10_bytes", 12, 96'h42_808080808080808080_7F_0B,
            expect_of(ENDED, 1'b0, I64, 64'h8000_0000_0000_0000));
    // -1 + 2 with a nop in between
    add_row("i32_add_wrap", 7, 56'h41_7F_01_41_02_6A_0B,
            expect_of(ENDED, 1'b0, I32, 64'h1));
    add_row("i32_sub_order", 6, 48'h41_03_41_05_6B_0B,
            expect_of(ENDED, 1'b0, I32, 64'h0000_0000_FFFF_FFFE));
    add_row("i64_add_carry", 11, 88'h42_FFFFFFFF0F_01_42_01_7C_0B,
            expect_of(ENDED, 1'b0, I64, 64'h0000_0001_0000_0000));
    // 0 - 2^62
    add_row("i64_sub_large", 15, 120'h42_00_42_8080808080808080C000_7D_0B,
            expect_of(ENDED, 1'b0, I64, 64'hC000_0000_0000_0000));
    add_row("i32_eq", 6, 48'h41_05_41_05_46_0B, expect_of(ENDED, 1'b0, I32, 64'h1));
    add_row("i32_ne", 6, 48'h41_07_41_07_47_0B, expect_of(ENDED, 1'b0, I32, 64'h0));
    add_row("i32_eqz", 4, 32'h41_05_45_0B, expect_of(ENDED, 1'b0, I32, 64'h0));
    // Values differ only above bit 31
    add_row("i64_eq_upper", 10, 80'h42_00_42_8080808010_51_0B,
            expect_of(ENDED, 1'b0, I32, 64'h0));
    add_row("i64_ne", 6, 48'h42_05_42_06_52_0B, expect_of(ENDED, 1'b0, I32, 64'h1));
    add_row("i64_eqz", 4, 32'h42_00_50_0B, expect_of(ENDED, 1'b0, I32, 64'h1));
    add_row("drop_below", 6, 48'h41_0A_41_14_1A_0B, expect_of(ENDED, 1'b0, I32, 64'h0A));
    add_row("unreachable", 3, 24'h41_2A_00, expect_of(UNREACH, 1'b0, I32, 64'h2A));
    add_row("unknown_opcode", 3, 24'h41_07_10, expect_of(UNKNOWN, 1'b0, I32, 64'h7));
    add_row("type_mismatch", 5, 40'h41_01_42_02_7C, expect_of(MISMATCH, 1'b0, I64, 64'h2));
    add_row("add_one_entry", 3, 24'h41_01_6A, expect_of(STACK_EMPTY, 1'b0, I32, 64'h1));
    add_row("drop_empty", 1, 8'h1A, expect_of(STACK_EMPTY, 1'b1, I32, 64'h0));
    add_row("overflow_nine", 18, 144'h4101_4102_4103_4104_4105_4106_4107_4108_4109,
            expect_of(OVERFLOW, 1'b0, I32, 64'h8));
  endtask

  // Load during reset and run until the core halts
  task automatic run_row(input int r);
    @(posedge clk);
    #1;
    reset    = 1'b1;
    cur_name = row_name[r];
    cur_exp  = row_exp[r];
    for (int i = 0; i < row_len[r]; i++) begin
      load_en   = 1'b1;
      load_addr = ROM_ADDR_BITS'(i);
      load_byte = row_code[r][8*(row_len[r]-1-i) +: 8];
      @(posedge clk);
      #1;
    end
    load_en = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
    while (trap == wasm_isa_pkg::TRAP_NONE) begin
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    load_en     = 1'b0;
    load_addr   = '0;
    load_byte   = '0;
    cur_name    = '0;
    cur_exp     = '0;
    row_count   = 0;
    current_row = 0;
    table_ready = 1'b0;
    build_table();
    table_ready = 1'b1;
    for (int r = 0; r < row_count; r++) begin
      current_row = r;
      run_row(r);
    end
    @(posedge clk);
    #1;
    assert_failures = dut0.u_core.assert0.failures;
    if (check_count != row_count) begin
      $display("Only %0d of %0d rows halted and were compared", check_count, row_count);
    end
    $display("Summary: %0d rows, %0d checked, %0d value errors, %0d assertion failures",
             row_count, check_count, error_count, assert_failures);
    if (error_count == 0 && assert_failures == 0 && check_count == row_count) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Budget of 3 cycles per program byte plus 20 per row
  initial begin
    int limit_cycles;
    wait (table_ready === 1'b1);
    limit_cycles = 0;
    for (int r = 0; r < row_count; r++) begin
      limit_cycles += 3 * row_len[r] + 20;
    end
    #(limit_cycles * CLK_PERIOD);
    $display("Timeout: row %0d never reached a trap within %0d cycles of run time",
             current_row, limit_cycles);
    $display("Done: errors found");
    $finish;
  end

endmodule
